// File: project.f
verilog/image_geom_pkg.sv
verilog/gradient_pkg.sv
verilog/ig_control.sv
verilog/scan_counter.sv
verilog/tap_delay_line.sv
verilog/gradient_unit.sv
verilog/image_gradient.sv
dv/image_gradient_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    --top-module image_gradient_tb -f project.f -o image_gradient_sim \
    && ./obj_dir/image_gradient_sim | tee /dev/stderr | grep -q "Simulation passed" \
    && echo "run ok" \
    || { echo "run FAILED"; exit 1; }

// File: dv/ig_patterns.txt
// one line per pixel in raster order, 8 x 8 image
// column 1: pixel value, column 2: expected gradient word {gx, gy}
00 3FCFF
FF C0701
00 3FC80
FF C4780
10 04002
20 04004
30 04006
40 00008
FF C0706
00 2000A
80 FFF8F
7F E4F95
12 04807
24 04BFA
36 04BED
48 003E0
05 01423
0A 01419
0F 0140F
14 01405
19 017FB
1E 017F1
23 017E7
28 003DD
28 FEC58
23 FEC5D
1E FEC62
19 FEC67
14 FEC6C
0F FEC71
0A FEC76
05 0007B
80 00380
80 00381
80 00382
80 00383
80 00384
80 00385
80 00386
80 00387
00 004C8
01 00463
02 00430
03 00416
04 00408
05 00401
06 007FD
07 003FA
C8 E7349
64 F3BBE
32 F9C01
19 FCC2B
0C FE849
06 FF460
03 FF874
01 00087
11 04400
22 04400
33 04400
44 04400
55 04400
66 04400
77 04400
88 00000

// File: dv/image_gradient_tb.sv
module image_gradient_tb
    import image_geom_pkg::*;
    import gradient_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = 2 * NUM_PIX + 100;
    localparam int SETTLE_CYCLES  = 4;

    logic              clk;
    logic              reset;
    logic              done;
    logic              img_wr;
    logic              img_rd;
    logic [ADDR_W-1:0] img_addr;
    pixel_t            img_di;
    pixel_t            img_do;
    logic              grad_wr;
    logic              grad_rd;
    logic [ADDR_W-1:0] grad_addr;
    grad_t             grad_do;
    grad_t             grad_di;

    // raw file words, pixel and gradient alternating
    logic [31:0] pattern_words [2*NUM_PIX];
    pixel_t      pixel_mem [NUM_PIX];
    grad_t       expected_grad [NUM_PIX];
    grad_t       captured_grad [NUM_PIX];
    int          write_hits [NUM_PIX];

    int   mismatch_count;
    int   failure_count;
    int   read_count;
    int   write_count;
    logic read_ended;
    logic done_seen;

    image_gradient i_image_gradient (
        .clk       (clk),
        .reset     (reset),
        .done      (done),
        .img_wr    (img_wr),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .img_do    (img_do),
        .grad_wr   (grad_wr),
        .grad_rd   (grad_rd),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .grad_di   (grad_di)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch %s: got %h expected %h", name, got, expected);
            mismatch_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t: %s", $time, what);
        failure_count++;
    endtask

    task automatic load_patterns();
        $readmemh("dv/ig_patterns.txt", pattern_words);
        for (int i = 0; i < NUM_PIX; i++) begin
            pixel_mem[i]     = pattern_words[2*i][PIX_W-1:0];
            expected_grad[i] = pattern_words[2*i+1][GRAD_W-1:0];
            captured_grad[i] = '0;
            write_hits[i]    = 0;
        end
    endtask

    task automatic check_results();
        for (int a = 0; a < NUM_PIX; a++) begin
            check_equal($sformatf("write count at address %0d", a), 32'(write_hits[a]), 32'd1);
            check_equal($sformatf("grad_do[%0d]", a), 32'(captured_grad[a]),
                        32'(expected_grad[a]));
            // border words, Gx in the upper half
            if (a % IMG_W == IMG_W - 1) begin
                check_equal($sformatf("gx at last column address %0d", a),
                            32'(captured_grad[a][GRAD_W-1:GCOMP_W]), 32'd0);
            end
            if (a >= NUM_PIX - IMG_W) begin
                check_equal($sformatf("gy at last row address %0d", a),
                            32'(captured_grad[a][GCOMP_W-1:0]), 32'd0);
            end
        end
        check_equal("read count", 32'(read_count), 32'(NUM_PIX));
        check_equal("write count", 32'(write_count), 32'(NUM_PIX));
        check_equal("done", 32'(done), 32'd1);
    endtask

    // ----------------------------------------
    // image memory model
    // ----------------------------------------
    always @(posedge clk) begin
        int addr;
        if (img_rd) begin
            addr = int'(img_addr);
            if (addr < NUM_PIX) begin
                img_di <= pixel_mem[addr];
            end else begin
                report_failure($sformatf("image read outside the image at address %0d", addr));
            end
        end
    end

    // ----------------------------------------
    // bus monitor and write capture
    // ----------------------------------------
    always @(posedge clk) begin
        int addr;
        if (!reset) begin
            check_equal("img_wr", 32'(img_wr), 32'd0);
            check_equal("img_do", 32'(img_do), 32'd0);
            check_equal("grad_rd", 32'(grad_rd), 32'd0);

            // one unbroken burst of reads
            if (img_rd) begin
                if (read_ended) begin
                    report_failure("img_rd rose again after the read phase");
                end
                check_equal("img_addr", 32'(img_addr), 32'(read_count));
                read_count++;
            end else if (read_count > 0) begin
                read_ended = 1'b1;
            end

            if (grad_wr) begin
                addr = int'(grad_addr);
                if (done || done_seen) begin
                    report_failure("grad_wr seen while done was high");
                end
                if (addr < NUM_PIX) begin
                    check_equal("grad_addr", 32'(grad_addr), 32'(write_count));
                    captured_grad[addr] = grad_do;
                    write_hits[addr]++;
                end else begin
                    report_failure($sformatf("gradient write outside the image at %0d", addr));
                end
                write_count++;
            end

            if (done) begin
                if (!done_seen) begin
                    check_equal("write count at done", 32'(write_count), 32'(NUM_PIX));
                end
                done_seen = 1'b1;
            end else if (done_seen) begin
                report_failure("done fell before the end of the run");
            end
        end
    end

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        int wait_cycles;

        reset          = 1'b1;
        img_di         = '0;
        grad_di        = '0;
        mismatch_count = 0;
        failure_count  = 0;
        read_count     = 0;
        write_count    = 0;
        read_ended     = 1'b0;
        done_seen      = 1'b0;
        load_patterns();

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // still idle, the engine has not yet seen reset low
        @(negedge clk);
        check_equal("img_rd", 32'(img_rd), 32'd0);
        check_equal("grad_wr", 32'(grad_wr), 32'd0);
        check_equal("done", 32'(done), 32'd0);

        // first read starts right away
        @(negedge clk);
        check_equal("img_rd", 32'(img_rd), 32'd1);
        check_equal("img_addr", 32'(img_addr), 32'd0);

        wait_cycles = RESET_CYCLES + 2;
        while (!done && wait_cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            wait_cycles++;
        end

        if (!done) begin
            report_failure($sformatf("done never rose within %0d cycles", TIMEOUT_CYCLES));
        end else begin
            // watch for stray writes after done
            repeat (SETTLE_CYCLES) @(negedge clk);
            check_results();
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog/image_gradient.sv
module image_gradient
    import image_geom_pkg::*;
    import gradient_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    output logic              done,
    output logic              img_wr,
    output logic              img_rd,
    output logic [ADDR_W-1:0] img_addr,
    input  pixel_t            img_di,
    output pixel_t            img_do,
    output logic              grad_wr,
    output logic              grad_rd,
    output logic [ADDR_W-1:0] grad_addr,
    output grad_t             grad_do,
    input  grad_t             grad_di
);

    logic              rd_last;
    logic              wr_last;
    logic              sample_valid;
    logic              read_phase;
    logic [ADDR_W-1:0] wr_addr;
    pixel_t            pix_above;
    pixel_t            pix_above_right;
    logic              ok_above;

    // image memory is read only, gradient memory write only
    assign img_wr  = 1'b0;
    assign img_do  = '0;
    assign grad_rd = 1'b0;

    // ----------------------------------------
    // control and addressing
    // ----------------------------------------
    ig_control i_ig_control (
        .clk          (clk),
        .reset        (reset),
        .rd_last      (rd_last),
        .wr_last      (wr_last),
        .img_rd       (img_rd),
        .sample_valid (sample_valid),
        .read_phase   (read_phase),
        .done         (done)
    );

    scan_counter i_scan_counter (
        .clk      (clk),
        .reset    (reset),
        .rd_step  (img_rd),
        .wr_step  (grad_wr),
        .img_addr (img_addr),
        .rd_last  (rd_last),
        .wr_addr  (wr_addr),
        .wr_last  (wr_last)
    );

    // ----------------------------------------
    // datapath
    // ----------------------------------------
    tap_delay_line #(
        .payload_t (pixel_t)
    ) i_pixel_line (
        .clk         (clk),
        .reset       (reset),
        .shift       (sample_valid),
        .din         (img_di),
        .above       (pix_above),
        .above_right (pix_above_right)
    );

    // marks which entries hold real pixels
    tap_delay_line #(
        .payload_t (logic)
    ) i_valid_line (
        .clk         (clk),
        .reset       (reset),
        .shift       (sample_valid),
        .din         (read_phase),
        .above       (ok_above),
        .above_right ()
    );

    gradient_unit i_gradient_unit (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .below        (img_di),
        .pixel        (pix_above),
        .right        (pix_above_right),
        .pixel_ok     (ok_above),
        .wr_addr      (wr_addr),
        .grad_wr      (grad_wr),
        .grad_addr    (grad_addr),
        .grad_do      (grad_do)
    );

endmodule

// File: verilog/gradient_unit.sv
module gradient_unit
    import image_geom_pkg::*;
    import gradient_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              sample_valid,
    input  pixel_t            below,
    input  pixel_t            pixel,
    input  pixel_t            right,
    input  logic              pixel_ok,
    input  logic [ADDR_W-1:0] wr_addr,
    output logic              grad_wr,
    output logic [ADDR_W-1:0] grad_addr,
    output grad_t             grad_do
);

    logic [ADDR_W-1:0] pix_addr;
    logic              last_col;
    logic              last_row;
    logic              wr_en;
    gcomp_t            below_s;
    gcomp_t            pixel_s;
    gcomp_t            right_s;
    gcomp_t            gx;
    gcomp_t            gy;

    // ----------------------------------------
    // border decode
    // ----------------------------------------
    // a write still in the output register is not yet counted in wr_addr
    assign pix_addr = wr_addr + ADDR_W'(grad_wr);
    assign last_col = (pix_addr[COL_W-1:0] == COL_W'(IMG_W - 1));
    assign last_row = (pix_addr >= ADDR_W'(NUM_PIX - IMG_W));

    // ----------------------------------------
    // differences
    // ----------------------------------------
    // zero extend before the signed subtract
    assign below_s = gcomp_t'(below);
    assign pixel_s = gcomp_t'(pixel);
    assign right_s = gcomp_t'(right);

    assign gx = last_col ? '0 : right_s - pixel_s;
    assign gy = last_row ? '0 : below_s - pixel_s;

    assign wr_en = sample_valid && pixel_ok;

    // write strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
        end else begin
            grad_wr <= wr_en;
        end
    end

    // write payload
    always_ff @(posedge clk) begin
        if (wr_en) begin
            grad_addr <= pix_addr;
            grad_do   <= {gx, gy};
        end
    end

endmodule

// File: verilog/tap_delay_line.sv
module tap_delay_line
    import image_geom_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     shift,
    input  payload_t din,
    output payload_t above,
    output payload_t above_right
);

    // together with din the window spans one row plus one entry
    // line_q[j] holds the sample j+1 shifts back
    payload_t line_q [IMG_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < IMG_W; i++) begin
                line_q[i] <= '0;
            end
        end else if (shift) begin
            line_q[0] <= din;
            for (int i = 1; i < IMG_W; i++) begin
                line_q[i] <= line_q[i-1];
            end
        end
    end

    // same column one row up, and its right neighbour
    assign above       = line_q[IMG_W-1];
    assign above_right = line_q[IMG_W-2];

endmodule

// File: verilog/scan_counter.sv
module scan_counter
    import image_geom_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              rd_step,
    input  logic              wr_step,
    output logic [ADDR_W-1:0] img_addr,
    output logic              rd_last,
    output logic [ADDR_W-1:0] wr_addr,
    output logic              wr_last
);

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(NUM_PIX - 1);

    // ----------------------------------------
    // read address
    // ----------------------------------------
    // address of the read issued in the current cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            img_addr <= '0;
        end else if (rd_step) begin
            img_addr <= img_addr + 1'b1;
        end
    end

    assign rd_last = (img_addr == LAST_ADDR);

    // ----------------------------------------
    // write address
    // ----------------------------------------
    // counts completed gradient writes
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_addr <= '0;
        end else if (wr_step) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    // high in the cycle of the final write
    assign wr_last = (wr_addr == LAST_ADDR);

endmodule

// File: verilog/ig_control.sv
module ig_control
    import image_geom_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic rd_last,
    input  logic wr_last,
    output logic img_rd,
    output logic sample_valid,
    output logic read_phase,
    output logic done
);

    typedef enum logic [1:0] {
        READ,
        FLUSH,
        DRAIN,
        FINISH
    } state_t;

    state_t           state;
    logic [COL_W-1:0] flush_cnt;

    // ----------------------------------------
    // phase sequencing
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= READ;
            img_rd       <= 1'b0;
            flush_cnt    <= '0;
            sample_valid <= 1'b0;
            read_phase   <= 1'b0;
        end else begin
            // memory answers one clock after the strobe, so samples lag by one
            read_phase   <= img_rd;
            sample_valid <= img_rd || (state == FLUSH);

            case (state)
                READ: begin
                    if (img_rd && rd_last) begin
                        img_rd <= 1'b0;
                        state  <= FLUSH;
                    end else begin
                        img_rd <= 1'b1;
                    end
                end
                FLUSH: begin
                    // one extra row of shifts pushes the last row past the taps
                    flush_cnt <= flush_cnt + 1'b1;
                    if (flush_cnt == COL_W'(IMG_W - 1)) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    // wr_last is seen in the cycle of the final write
                    if (wr_last) begin
                        state <= FINISH;
                    end
                end
                default: begin
                    state <= FINISH;
                end
            endcase
        end
    end

    assign done = (state == FINISH);

endmodule

// File: verilog/gradient_pkg.sv
package gradient_pkg;

    // one signed difference, wide enough for -255..255
    localparam int GCOMP_W = 10;
    localparam int GRAD_W  = 2 * GCOMP_W;

    typedef logic signed [GCOMP_W-1:0] gcomp_t;

    // Gx in the upper half, Gy in the lower half
    typedef logic [GRAD_W-1:0] grad_t;

endpackage

// File: verilog/image_geom_pkg.sv
package image_geom_pkg;

    // ----------------------------------------
    // image geometry
    // ----------------------------------------
    // width and height must be powers of two
    localparam int IMG_W   = 8;
    localparam int IMG_H   = 8;
    localparam int NUM_PIX = IMG_W * IMG_H;

    // address bus width of both external memories
    localparam int ADDR_W = 16;

    // low address bits select the column
    localparam int COL_W = $clog2(IMG_W);

    // greyscale pixel
    localparam int PIX_W = 8;

    typedef logic [PIX_W-1:0] pixel_t;

endpackage
